// ==== vlog.f ====
verilog/icache_pkg.sv
verilog/icache_line_ram.sv
verilog/instruction_cache.sv
verilog/bus_arbiter.sv
verilog/wb_program_ram.sv
verilog/fetch_subsystem.sv
testbench/tb_clock_gen.sv
testbench/fetch_subsystem_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = fetch_subsystem_tb
FILELIST = vlog.f
OBJ_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/fetch_subsystem_tb.sv ====
`default_nettype none

module fetch_subsystem_tb;

  localparam int SEED = 32'h2b07607c;
  localparam int DRIVE_DELAY = 1;
  localparam int SETTLE = 2;
  localparam int RESET_CYCLES = 8;
  localparam int RAM_WORDS = 2 ** icache_pkg::RAM_ADDR_BITS;
  localparam int CACHE_LINES = 2 ** icache_pkg::LINE_COUNT;
  localparam int FETCH_RUNS = 3;
  localparam int RUN_LEN = 16;
  // program words sit below the vector table at word 0x380
  localparam int PROGRAM_WORDS = 'h380 - RUN_LEN;
  localparam int VTABLE_WORDS = 128;
  localparam int VECTOR_LOOKUPS = 4;
  localparam int HOLD_CYCLES = 20;
  localparam int TAIL_CYCLES = 4;
  localparam int BUSY_TIMEOUT = 200;
  localparam int PLANNED_FETCHES = FETCH_RUNS * RUN_LEN + 2 + (CACHE_LINES + 2) + 1;
  localparam int WATCHDOG_CYCLES = 200 * PLANNED_FETCHES + 2000;

  typedef enum logic [1:0] {CMP_WORD, CMP_FLAG, CMP_VECTOR} cmp_kind_t;

  typedef struct packed {
    cmp_kind_t kind;
    icache_pkg::word_t got;
    icache_pkg::word_t exp;
  } cmp_item_t;

  logic clk_i;
  logic reset_i;
  logic advance_i;
  icache_pkg::addr_t addr_i;
  icache_pkg::word_t instruction_o;
  logic busy_o;
  logic cache_miss_o;
  logic interrupt_trigger_i;
  icache_pkg::addr_t vtable_offset_i;
  logic interrupt_grant_o;
  icache_pkg::word_t vector_pc_o;
  logic vector_pc_valid_o;
  logic ld_req_i;
  logic ld_grant_o;
  icache_pkg::wb_req_t ld_wb_i;
  icache_pkg::wb_rsp_t ld_wb_o;

  // shadow of the program RAM and of the cache tags
  icache_pkg::word_t shadow [RAM_WORDS];
  icache_pkg::tag_t model_tag [CACHE_LINES];
  logic [CACHE_LINES-1:0] model_valid;
  int model_ptr;

  cmp_item_t cmp_q [$];
  string name_q [$];
  int checks_posted;
  int checks_done;
  int error_count;
  int test_count;
  int test_start_errors;

  tb_clock_gen clock_gen (
    .clk_o(clk_i)
  );

  fetch_subsystem fetch_subsystem_inst (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .advance_i(advance_i),
    .addr_i(addr_i),
    .instruction_o(instruction_o),
    .busy_o(busy_o),
    .cache_miss_o(cache_miss_o),
    .interrupt_trigger_i(interrupt_trigger_i),
    .vtable_offset_i(vtable_offset_i),
    .interrupt_grant_o(interrupt_grant_o),
    .vector_pc_o(vector_pc_o),
    .vector_pc_valid_o(vector_pc_valid_o),
    .ld_req_i(ld_req_i),
    .ld_grant_o(ld_grant_o),
    .ld_wb_i(ld_wb_i),
    .ld_wb_o(ld_wb_o)
  );

  function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t a);
    return shadow[a[icache_pkg::RAM_ADDR_BITS+1:2]];
  endfunction

  // table base plus offset rounded down to a word
  function automatic icache_pkg::word_t expected_vector(input icache_pkg::addr_t off);
    icache_pkg::addr_t entry;
    entry = icache_pkg::VTABLE_ADDRESS + {off[31:2], 2'b00};
    return shadow[entry[icache_pkg::RAM_ADDR_BITS+1:2]];
  endfunction

  // tag lookup, a miss takes the round-robin victim
  function automatic logic expected_hit(input icache_pkg::addr_t a);
    icache_pkg::tag_t tag;
    logic hit;
    tag = a[icache_pkg::XLEN-icache_pkg::UNUSED_ADDR_BITS-1 -: icache_pkg::TAG_WIDTH];
    hit = 1'b0;
    for (int i = 0; i < CACHE_LINES; i++) begin
      if (model_valid[i] && model_tag[i] == tag) begin
        hit = 1'b1;
      end
    end
    if (!hit) begin
      model_tag[model_ptr] = tag;
      model_valid[model_ptr] = 1'b1;
      model_ptr = (model_ptr + 1) % CACHE_LINES;
    end
    return hit;
  endfunction

  task automatic check_word(input string name, input icache_pkg::word_t got,
                            input icache_pkg::word_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_vector(input string name, input icache_pkg::word_t got,
                              input icache_pkg::word_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic post_check(input cmp_kind_t kind, input string name,
                            input icache_pkg::word_t got, input icache_pkg::word_t exp);
    cmp_q.push_back('{kind: kind, got: got, exp: exp});
    name_q.push_back(name);
    checks_posted++;
  endtask

  // compare process
  initial begin : compare_results
    cmp_item_t item;
    string name;
    forever begin
      wait (checks_posted != checks_done);
      item = cmp_q.pop_front();
      name = name_q.pop_front();
      case (item.kind)
        CMP_WORD: check_word(name, item.got, item.exp);
        CMP_FLAG: check_flag(name, item.got[0], item.exp[0]);
        default: check_vector(name, item.got, item.exp);
      endcase
      checks_done++;
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  task automatic next_cycle();
    @(posedge clk_i);
    #DRIVE_DELAY;
  endtask

  task automatic finish_test(input string name);
    int errs;
    wait (checks_done == checks_posted);
    errs = error_count - test_start_errors;
    test_count++;
    if (errs == 0) begin
      $display("test %0d %s: pass", test_count, name);
    end else begin
      $display("test %0d %s: fail with %0d errors", test_count, name, errs);
    end
    test_start_errors = error_count;
  endtask

  task automatic wait_not_busy(input string what, output int cycles);
    cycles = 0;
    while (busy_o && cycles < BUSY_TIMEOUT) begin
      next_cycle();
      cycles++;
    end
    if (busy_o) begin
      $display("ERROR: busy_o still high after %0d cycles in %s", BUSY_TIMEOUT, what);
      error_count++;
    end
  endtask

  task automatic wait_loader_grant();
    int waited;
    waited = 0;
    while (!ld_grant_o && waited < BUSY_TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (!ld_grant_o) begin
      $display("ERROR: loader was never granted the bus");
      error_count++;
    end
  endtask

  // writes random words over the whole RAM
  task automatic load_program();
    int waited;
    ld_req_i = 1'b1;
    wait_loader_grant();
    for (int i = 0; i < RAM_WORDS; i++) begin
      shadow[i] = $urandom();
      ld_wb_i.cyc = 1'b1;
      ld_wb_i.stb = 1'b1;
      ld_wb_i.we = 1'b1;
      ld_wb_i.adr = icache_pkg::wb_adr_t'(i);
      ld_wb_i.dat = shadow[i];
      ld_wb_i.sel = 4'hf;
      next_cycle();
      waited = 0;
      while (!ld_wb_o.ack && waited < BUSY_TIMEOUT) begin
        next_cycle();
        waited++;
      end
      if (!ld_wb_o.ack) begin
        $display("ERROR: no ack for loader write to word %0d", i);
        error_count++;
      end
    end
    ld_wb_i = '0;
    ld_req_i = 1'b0;
    next_cycle();
  endtask

  // fetch after a fill, must hit
  task automatic refetch_hit(input icache_pkg::addr_t a);
    logic predict_hit;
    predict_hit = expected_hit(a);
    advance_i = 1'b1;
    next_cycle();
    advance_i = 1'b0;
    post_check(CMP_FLAG, "busy_o", icache_pkg::word_t'(busy_o),
               icache_pkg::word_t'(!predict_hit));
  endtask

  task automatic fetch(input icache_pkg::addr_t a, output logic missed);
    logic predict_hit;
    int cycles;
    predict_hit = expected_hit(a);
    addr_i = a;
    advance_i = 1'b1;
    #SETTLE;
    post_check(CMP_FLAG, "cache_miss_o", icache_pkg::word_t'(cache_miss_o),
               icache_pkg::word_t'(!predict_hit));
    next_cycle();
    advance_i = 1'b0;
    missed = busy_o;
    post_check(CMP_FLAG, "busy_o", icache_pkg::word_t'(busy_o),
               icache_pkg::word_t'(!predict_hit));
    if (busy_o) begin
      wait_not_busy("line fill", cycles);
      refetch_hit(a);
    end
    post_check(CMP_WORD, "instruction_o", instruction_o, expected_word(a));
  endtask

  initial begin : stimulus
    icache_pkg::addr_t a;
    icache_pkg::addr_t first;
    icache_pkg::addr_t offset;
    icache_pkg::word_t got;
    logic missed;
    logic predicted_hit;
    int idx;
    int grants;
    int valids;
    int cycles;

    reset_i = 1'b1;
    advance_i = 1'b0;
    addr_i = '0;
    interrupt_trigger_i = 1'b0;
    vtable_offset_i = '0;
    ld_req_i = 1'b0;
    ld_wb_i = '0;
    model_valid = '0;
    model_ptr = 0;
    checks_posted = 0;
    checks_done = 0;
    error_count = 0;
    test_count = 0;
    test_start_errors = 0;
    void'($urandom(SEED));

    repeat (RESET_CYCLES) next_cycle();
    reset_i = 1'b0;
    next_cycle();

    // all tags invalid after reset
    post_check(CMP_FLAG, "busy_o", icache_pkg::word_t'(busy_o), '0);
    post_check(CMP_FLAG, "interrupt_grant_o", icache_pkg::word_t'(interrupt_grant_o), '0);
    post_check(CMP_FLAG, "vector_pc_valid_o", icache_pkg::word_t'(vector_pc_valid_o), '0);
    post_check(CMP_FLAG, "ld_grant_o", icache_pkg::word_t'(ld_grant_o), '0);
    post_check(CMP_VECTOR, "vector_pc_o", vector_pc_o, '0);
    repeat (4) begin
      addr_i = $urandom();
      #SETTLE;
      post_check(CMP_FLAG, "cache_miss_o", icache_pkg::word_t'(cache_miss_o), 32'd1);
      next_cycle();
    end
    finish_test("reset state");

    load_program();
    for (int r = 0; r < FETCH_RUNS; r++) begin
      a = ($urandom() % PROGRAM_WORDS) << 2;
      for (int k = 0; k < RUN_LEN; k++) begin
        fetch(a + k * 4, missed);
      end
    end
    finish_test("load and sequential fetch");

    // upper tag bits fold onto the same RAM words
    idx = int'($urandom() % 16);
    a = 32'h0010_0000 | (idx << 2);
    fetch(a, missed);
    idx = (idx + 1 + int'($urandom() % 15)) % 16;
    a = {a[31:6], icache_pkg::word_sel_t'(idx), 2'b00};
    fetch(a, missed);
    post_check(CMP_FLAG, "busy_o on reused line", icache_pkg::word_t'(missed), '0);
    finish_test("line reuse");

    first = 32'h0020_0000 | (($urandom() % 16) << 2);
    a = first;
    for (int k = 0; k <= CACHE_LINES; k++) begin
      fetch(a, missed);
      a = a + 64;
    end
    fetch(first, missed);
    post_check(CMP_FLAG, "busy_o on evicted line", icache_pkg::word_t'(missed), 32'd1);
    finish_test("replacement");

    for (int v = 0; v < VECTOR_LOOKUPS; v++) begin
      offset = ($urandom() % VTABLE_WORDS) << 2;
      vtable_offset_i = offset;
      interrupt_trigger_i = 1'b1;
      next_cycle();
      interrupt_trigger_i = 1'b0;
      post_check(CMP_FLAG, "interrupt_grant_o", icache_pkg::word_t'(interrupt_grant_o), 32'd1);
      post_check(CMP_FLAG, "busy_o during lookup", icache_pkg::word_t'(busy_o), 32'd1);
      grants = interrupt_grant_o ? 1 : 0;
      valids = 0;
      cycles = 0;
      got = '0;
      while (valids == 0 && cycles < BUSY_TIMEOUT) begin
        next_cycle();
        cycles++;
        grants += interrupt_grant_o ? 1 : 0;
        if (vector_pc_valid_o) begin
          valids++;
          got = vector_pc_o;
        end
      end
      if (valids == 0) begin
        $display("ERROR: vector_pc_valid_o never pulsed for offset 0x%08h", offset);
        error_count++;
      end
      repeat (TAIL_CYCLES) begin
        next_cycle();
        grants += interrupt_grant_o ? 1 : 0;
        valids += vector_pc_valid_o ? 1 : 0;
      end
      post_check(CMP_FLAG, "interrupt_grant_o pulse count",
                 icache_pkg::word_t'(grants == 1), 32'd1);
      post_check(CMP_FLAG, "vector_pc_valid_o pulse count",
                 icache_pkg::word_t'(valids == 1), 32'd1);
      post_check(CMP_VECTOR, "vector_pc_o", got, expected_vector(offset));
    end
    finish_test("vector lookup");

    // loader sits on the bus while the cache misses
    ld_req_i = 1'b1;
    wait_loader_grant();
    a = 32'h0030_0000 | (($urandom() % 16) << 2);
    predicted_hit = expected_hit(a);
    addr_i = a;
    advance_i = 1'b1;
    #SETTLE;
    post_check(CMP_FLAG, "cache_miss_o", icache_pkg::word_t'(cache_miss_o),
               icache_pkg::word_t'(!predicted_hit));
    next_cycle();
    advance_i = 1'b0;
    for (int k = 0; k < HOLD_CYCLES; k++) begin
      post_check(CMP_FLAG, "busy_o while loader holds bus", icache_pkg::word_t'(busy_o), 32'd1);
      post_check(CMP_FLAG, "ld_grant_o while loader holds bus",
                 icache_pkg::word_t'(ld_grant_o), 32'd1);
      next_cycle();
    end
    ld_req_i = 1'b0;
    wait_not_busy("contended fill", cycles);
    refetch_hit(a);
    post_check(CMP_WORD, "instruction_o", instruction_o, expected_word(a));
    finish_test("contention");

    wait (checks_done == checks_posted);
    $display("tests %0d, checks %0d, errors %0d", test_count, checks_done, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
  output logic clk_o
);

  // period of 10
  localparam int HALF_PERIOD = 5;

  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fetch_subsystem.sv ====
`default_nettype none

module fetch_subsystem (
  input wire clk_i,
  input wire reset_i,

  // fetch port
  input wire advance_i,
  input wire icache_pkg::addr_t addr_i,
  output icache_pkg::word_t instruction_o,
  output logic busy_o,
  output logic cache_miss_o,

  // interrupt vector lookup
  input wire interrupt_trigger_i,
  input wire icache_pkg::addr_t vtable_offset_i,
  output logic interrupt_grant_o,
  output icache_pkg::word_t vector_pc_o,
  output logic vector_pc_valid_o,

  // loader master
  input wire ld_req_i,
  output logic ld_grant_o,
  input wire icache_pkg::wb_req_t ld_wb_i,
  output icache_pkg::wb_rsp_t ld_wb_o
);

  logic cache_req;
  logic cache_grant;
  icache_pkg::wb_req_t cache_wb;
  icache_pkg::wb_req_t ram_wb;
  icache_pkg::wb_rsp_t ram_rsp;

  // both masters see the same response
  assign ld_wb_o = ram_rsp;

  instruction_cache icache (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .advance_i(advance_i),
    .addr_i(addr_i),
    .instruction_o(instruction_o),
    .busy_o(busy_o),
    .cache_miss_o(cache_miss_o),
    .interrupt_trigger_i(interrupt_trigger_i),
    .vtable_offset_i(vtable_offset_i),
    .interrupt_grant_o(interrupt_grant_o),
    .vector_pc_o(vector_pc_o),
    .vector_pc_valid_o(vector_pc_valid_o),
    .bus_req_o(cache_req),
    .bus_grant_i(cache_grant),
    .wb_o(cache_wb),
    .wb_i(ram_rsp)
  );

  bus_arbiter arbiter (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .req0_i(cache_req),
    .req1_i(ld_req_i),
    .grant0_o(cache_grant),
    .grant1_o(ld_grant_o),
    .m0_i(cache_wb),
    .m1_i(ld_wb_i),
    .s_o(ram_wb)
  );

  wb_program_ram program_ram (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .wb_i(ram_wb),
    .wb_o(ram_rsp)
  );

endmodule

`default_nettype wire

// ==== verilog/wb_program_ram.sv ====
`default_nettype none

module wb_program_ram (
  input wire clk_i,
  input wire reset_i,
  input wire icache_pkg::wb_req_t wb_i,
  output icache_pkg::wb_rsp_t wb_o
);

  icache_pkg::word_t mem [2 ** icache_pkg::RAM_ADDR_BITS];

  logic [icache_pkg::RAM_ADDR_BITS-1:0] word_addr;
  logic access;
  logic ack_q;
  icache_pkg::word_t rdata_q;

  // upper address bits fold onto the 1024 words
  assign word_addr = wb_i.adr[icache_pkg::RAM_ADDR_BITS-1:0];

  // a new access only after an ack-free cycle
  assign access = wb_i.cyc & wb_i.stb & ~ack_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (wb_i.we) begin
        mem[word_addr] <= wb_i.dat;
      end
      rdata_q <= mem[word_addr];
    end
  end

  assign wb_o = '{ack: ack_q, dat: rdata_q};

  // a master drops stb only in or just after its ack cycle
  stb_held_until_ack: assert property (@(posedge clk_i) disable iff (reset_i)
    $fell(wb_i.stb) |-> ack_q || $past(ack_q));

endmodule

`default_nettype wire

// ==== verilog/bus_arbiter.sv ====
`default_nettype none

module bus_arbiter (
  input wire clk_i,
  input wire reset_i,
  input wire req0_i,
  input wire req1_i,
  output logic grant0_o,
  output logic grant1_o,
  input wire icache_pkg::wb_req_t m0_i,
  input wire icache_pkg::wb_req_t m1_i,
  output icache_pkg::wb_req_t s_o
);

  // owner keeps the bus until its req drops
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      grant0_o <= 1'b0;
      grant1_o <= 1'b0;
    end else if (grant0_o) begin
      grant0_o <= req0_i;
    end else if (grant1_o) begin
      grant1_o <= req1_i;
    end else begin
      // free bus, master 0 wins a tie
      grant0_o <= req0_i;
      grant1_o <= req1_i & ~req0_i;
    end
  end

  always_comb begin
    s_o = '0;
    if (grant0_o) begin
      s_o = m0_i;
    end else if (grant1_o) begin
      s_o = m1_i;
    end
  end

  one_owner: assert property (@(posedge clk_i) disable iff (reset_i)
    !(grant0_o && grant1_o));

endmodule

`default_nettype wire

// ==== verilog/instruction_cache.sv ====
`default_nettype none

module instruction_cache (
  input wire clk_i,
  input wire reset_i,

  // fetch port
  input wire advance_i,
  input wire icache_pkg::addr_t addr_i,
  output icache_pkg::word_t instruction_o,
  output logic busy_o,
  output logic cache_miss_o,

  // interrupt vector lookup
  input wire interrupt_trigger_i,
  input wire icache_pkg::addr_t vtable_offset_i,
  output logic interrupt_grant_o,
  output icache_pkg::word_t vector_pc_o,
  output logic vector_pc_valid_o,

  // bus master side
  output logic bus_req_o,
  input wire bus_grant_i,
  output icache_pkg::wb_req_t wb_o,
  input wire icache_pkg::wb_rsp_t wb_i
);

  icache_pkg::fill_state_t fill_state;
  icache_pkg::vec_state_t vec_state;

  icache_pkg::tag_t tags [2 ** icache_pkg::LINE_COUNT];
  logic [(2 ** icache_pkg::LINE_COUNT)-1:0] tag_valid;

  icache_pkg::tag_t addr_tag;
  icache_pkg::word_sel_t addr_word;
  icache_pkg::line_t hit_line;
  logic hit;

  logic accept;
  logic start_fill;
  icache_pkg::tag_t fill_tag;
  icache_pkg::word_sel_t fill_idx;
  icache_pkg::line_t current_line;
  icache_pkg::wb_adr_t fill_adr;
  logic fill_stb;
  logic fill_owns_bus;

  icache_pkg::wb_adr_t vec_adr;
  logic vec_stb;

  assign addr_tag = addr_i[icache_pkg::XLEN-1-icache_pkg::UNUSED_ADDR_BITS:
                           icache_pkg::LINE_LEN+2];
  assign addr_word = addr_i[icache_pkg::LINE_LEN+1:2];

  // tag compare against all eight lines
  always_comb begin
    hit = 1'b0;
    hit_line = '0;
    for (int i = 0; i < (2 ** icache_pkg::LINE_COUNT); i++) begin
      if (tag_valid[i] && tags[i] == addr_tag) begin
        hit = 1'b1;
        hit_line = icache_pkg::line_t'(i);
      end
    end
  end

  assign cache_miss_o = ~hit;
  assign busy_o = (fill_state != icache_pkg::FILL_IDLE) || (vec_state != icache_pkg::VEC_IDLE);

  // advances during a fill or a lookup are dropped
  assign accept = advance_i & ~busy_o;
  assign start_fill = accept & ~hit;

  icache_line_ram line_ram (
    .clk_i(clk_i),
    .write_i(fill_stb & wb_i.ack),
    .read_i(accept),
    .waddr_i({current_line, fill_idx}),
    .raddr_i({hit_line, addr_word}),
    .data_i(wb_i.dat),
    .data_o(instruction_o)
  );

  assign fill_stb = (fill_state == icache_pkg::FILL_READ);
  assign fill_owns_bus = (fill_state == icache_pkg::FILL_ARB) || fill_stb;
  assign fill_adr = {{icache_pkg::UNUSED_ADDR_BITS{1'b0}}, fill_tag, fill_idx};

  // line fill FSM
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fill_state <= icache_pkg::FILL_IDLE;
      fill_idx <= '0;
      current_line <= '0;
      tag_valid <= '0;
    end else begin
      case (fill_state)
        icache_pkg::FILL_IDLE: begin
          if (start_fill) begin
            // victim line stops matching while it is overwritten
            tag_valid[current_line] <= 1'b0;
            fill_idx <= '0;
            fill_state <= icache_pkg::FILL_ARB;
          end
        end
        icache_pkg::FILL_ARB: begin
          if (bus_grant_i && vec_state != icache_pkg::VEC_READ) begin
            fill_state <= icache_pkg::FILL_READ;
          end
        end
        icache_pkg::FILL_READ: begin
          if (wb_i.ack) begin
            fill_idx <= fill_idx + 1'b1;
            if (&fill_idx) begin
              fill_state <= icache_pkg::FILL_DONE;
            end
          end
        end
        default: begin
          tag_valid[current_line] <= 1'b1;
          current_line <= current_line + 1'b1;
          fill_state <= icache_pkg::FILL_IDLE;
        end
      endcase
    end
  end

  // tag storage
  always_ff @(posedge clk_i) begin
    if (start_fill) begin
      fill_tag <= addr_tag;
    end
    if (fill_state == icache_pkg::FILL_DONE) begin
      tags[current_line] <= fill_tag;
    end
  end

  assign vec_stb = (vec_state == icache_pkg::VEC_READ);

  // vector table lookup FSM
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      vec_state <= icache_pkg::VEC_IDLE;
      interrupt_grant_o <= 1'b0;
      vector_pc_valid_o <= 1'b0;
      vector_pc_o <= '0;
    end else begin
      interrupt_grant_o <= 1'b0;
      vector_pc_valid_o <= 1'b0;
      case (vec_state)
        icache_pkg::VEC_IDLE: begin
          if (interrupt_trigger_i) begin
            interrupt_grant_o <= 1'b1;
            vec_state <= icache_pkg::VEC_ARB;
          end
        end
        icache_pkg::VEC_ARB: begin
          // a pending fill goes first
          if (bus_grant_i && !fill_owns_bus) begin
            vec_state <= icache_pkg::VEC_READ;
          end
        end
        icache_pkg::VEC_READ: begin
          if (wb_i.ack) begin
            vector_pc_o <= wb_i.dat;
            vector_pc_valid_o <= 1'b1;
            vec_state <= icache_pkg::VEC_DONE;
          end
        end
        default: begin
          vec_state <= icache_pkg::VEC_IDLE;
        end
      endcase
    end
  end

  // table entry address, offset rounded down to a word
  always_ff @(posedge clk_i) begin
    if (vec_state == icache_pkg::VEC_IDLE && interrupt_trigger_i) begin
      vec_adr <= icache_pkg::VTABLE_ADDRESS[icache_pkg::XLEN-1:2]
                 + vtable_offset_i[icache_pkg::XLEN-1:2];
    end
  end

  assign bus_req_o = fill_owns_bus || (vec_state == icache_pkg::VEC_ARB) || vec_stb;

  // one master port for both machines
  always_comb begin
    wb_o = '0;
    wb_o.sel = 4'b1111;
    if (fill_stb) begin
      wb_o.cyc = 1'b1;
      wb_o.stb = 1'b1;
      wb_o.adr = fill_adr;
    end else if (vec_stb) begin
      wb_o.cyc = 1'b1;
      wb_o.stb = 1'b1;
      wb_o.adr = vec_adr;
    end
  end

  stb_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
    !(fill_stb && vec_stb));

  stb_needs_grant: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_o.stb |-> bus_grant_i);

endmodule

`default_nettype wire

// ==== verilog/icache_line_ram.sv ====
`default_nettype none

module icache_line_ram (
  input wire clk_i,
  input wire write_i,
  input wire read_i,
  input wire icache_pkg::cache_idx_t waddr_i,
  input wire icache_pkg::cache_idx_t raddr_i,
  input wire icache_pkg::word_t data_i,
  output icache_pkg::word_t data_o
);

  icache_pkg::word_t mem [2 ** icache_pkg::CACHE_LEN];

  // fill side
  always_ff @(posedge clk_i) begin
    if (write_i) begin
      mem[waddr_i] <= data_i;
    end
  end

  // fetch side, output holds until the next enabled read
  always_ff @(posedge clk_i) begin
    if (read_i) begin
      data_o <= mem[raddr_i];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  // address and data widths
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [XLEN-1:0] addr_t;
  typedef logic [XLEN-3:0] wb_adr_t;

  // cache geometry, 128 words in 8 lines of 16
  localparam int CACHE_LEN = 7;
  localparam int LINE_LEN = 4;
  localparam int LINE_COUNT = 3;

  typedef logic [CACHE_LEN-1:0] cache_idx_t;
  typedef logic [LINE_LEN-1:0] word_sel_t;
  typedef logic [LINE_COUNT-1:0] line_t;

  // top address byte is ignored by the tag compare
  localparam int UNUSED_ADDR_BITS = 8;
  localparam int TAG_WIDTH = XLEN - 2 - LINE_LEN - UNUSED_ADDR_BITS;

  typedef logic [TAG_WIDTH-1:0] tag_t;

  // program RAM depth in words, and vector table base
  localparam int RAM_ADDR_BITS = 10;
  localparam addr_t VTABLE_ADDRESS = 32'h0000_0E00;

  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    wb_adr_t adr;
    word_t dat;
    logic [3:0] sel;
  } wb_req_t;

  typedef struct packed {
    logic ack;
    word_t dat;
  } wb_rsp_t;

  typedef enum logic [1:0] {FILL_IDLE, FILL_ARB, FILL_READ, FILL_DONE} fill_state_t;
  typedef enum logic [1:0] {VEC_IDLE, VEC_ARB, VEC_READ, VEC_DONE} vec_state_t;

endpackage

`default_nettype wire
